//--- design/mmu_pkg.sv
package mmu_pkg;

    // address and page geometry for sv32
    localparam int VA_W       = 32;
    localparam int PA_W       = 34;
    // reachable physical space, anything above is an access fault
    localparam int BUS_W      = 32;
    localparam int PPN_W      = 22;
    localparam int VPN_W      = 20;
    localparam int VPN_LVL_W  = 10;
    localparam int PAGE_OFS_W = 12;

    // page table entry
    localparam int PTE_W      = 32;
    localparam int PTE_BYTES  = 4;

    // privilege encoding as in mstatus.mpp
    typedef enum logic [1:0] {
        PRV_U = 2'd0,
        PRV_S = 2'd1,
        PRV_M = 2'd3
    } prv_e;

    typedef enum logic [1:0] {
        ACC_READ  = 2'd0,
        ACC_WRITE = 2'd1,
        ACC_EXEC  = 2'd2
    } access_e;

    // walker states
    // mreq waits for the read data, pte evaluates the entry just read
    typedef enum logic [1:0] {
        WALK_IDLE = 2'd0,
        WALK_MREQ = 2'd1,
        WALK_PTE  = 2'd2
    } walk_state_e;

    // sv32 pte, msb first
    typedef struct packed {
        logic [PPN_W-1:0] ppn;
        logic [1:0]       rsw;
        logic             d;
        logic             a;
        logic             g;
        logic             u;
        logic             x;
        logic             w;
        logic             r;
        logic             v;
    } pte_t;

endpackage

//--- design/mmu_ifs.sv
`timescale 1ns/1ps

// resolver to walker, one walk per start pulse
interface walk_if import mmu_pkg::*; ();
    logic             start;
    logic [VPN_W-1:0] vpn;
    logic             done;
    logic             fault;
    logic             bus_err;
    pte_t             pte;
    logic             superpage;

    modport resolver (
        output start, vpn,
        input  done, fault, bus_err, pte, superpage
    );
    modport walker (
        input  start, vpn,
        output done, fault, bus_err, pte, superpage
    );
endinterface

// walker writes a good leaf into the last-translation entry
interface fill_if import mmu_pkg::*; ();
    logic             fill;
    logic [VPN_W-1:0] vpn;
    logic             superpage;
    pte_t             pte;

    modport walker (output fill, vpn, superpage, pte);
    modport cache  (input  fill, vpn, superpage, pte);
endinterface

interface lookup_if import mmu_pkg::*; ();
    logic [VPN_W-1:0] vpn;
    logic             miss_clear;
    logic             hit;
    pte_t             pte;
    logic             superpage;

    modport resolver (output vpn, miss_clear, input hit, pte, superpage);
    modport cache    (input vpn, miss_clear, output hit, pte, superpage);
endinterface

//--- design/last_xlat_cache.sv
`timescale 1ns/1ps

module last_xlat_cache import mmu_pkg::*; (
    input  logic    clk,
    input  logic    rstn,
    input  logic    tlb_flush_req,
    fill_if.cache   fill,
    lookup_if.cache lookup
);

    logic             valid_q;
    logic [VPN_W-1:0] vpn_q;
    logic             sp_q;
    pte_t             pte_q;

    logic [VPN_W-1:0] vpn_cmp;
    logic [VPN_W-1:0] vpn_fill;

    // a superpage ignores the level-0 index
    assign vpn_cmp = {lookup.vpn[VPN_W-1:VPN_LVL_W],
                      lookup.vpn[VPN_LVL_W-1:0] & {VPN_LVL_W{!sp_q}}};

    assign vpn_fill = {fill.vpn[VPN_W-1:VPN_LVL_W],
                       fill.vpn[VPN_LVL_W-1:0] & {VPN_LVL_W{!fill.superpage}}};

    assign lookup.hit       = valid_q && (vpn_cmp == vpn_q);
    assign lookup.pte       = pte_q;
    assign lookup.superpage = sp_q;

    // flush wins over a fill in the same cycle
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q <= 1'b0;
        end else if (tlb_flush_req || lookup.miss_clear) begin
            valid_q <= 1'b0;
        end else if (fill.fill) begin
            valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill.fill) begin
            vpn_q <= vpn_fill;
            sp_q  <= fill.superpage;
            pte_q <= fill.pte;
        end
    end

endmodule

//--- design/page_walker.sv
`timescale 1ns/1ps

module page_walker import mmu_pkg::*; (
    input  logic             clk,
    input  logic             rstn,
    input  logic [PPN_W-1:0] satp_ppn,
    walk_if.walker           walk,
    fill_if.walker           fill,
    output logic             mem_ar_valid,
    output logic [BUS_W-1:0] mem_ar_addr,
    input  logic             mem_ar_ready,
    input  logic             mem_r_valid,
    input  logic [PTE_W-1:0] mem_r_data,
    input  logic             mem_r_err
);

    walk_state_e          state;
    walk_state_e          state_nxt;

    // 1 while reading the root table
    logic                 level;
    logic                 ar_done;
    logic [PPN_W-1:0]     ppn_q;
    logic [VPN_W-1:0]     vpn_q;
    pte_t                 pte_q;

    logic [VPN_LVL_W-1:0] idx;
    logic [PA_W-1:0]      pte_addr;
    logic                 leaf;
    logic                 struct_fault;
    logic                 r_err;
    logic                 walk_end;

    assign idx      = level ? vpn_q[VPN_W-1:VPN_LVL_W] : vpn_q[VPN_LVL_W-1:0];
    assign pte_addr = {ppn_q, {PAGE_OFS_W{1'b0}}} + PA_W'(idx * PTE_BYTES);

    assign mem_ar_valid = (state == WALK_MREQ) && !ar_done;
    assign mem_ar_addr  = pte_addr[BUS_W-1:0];

    assign leaf = pte_q.v && (pte_q.r || pte_q.x);

    // invalid, w without r, pointer at the last level, misaligned superpage
    assign struct_fault = !pte_q.v
                       || (pte_q.w && !pte_q.r)
                       || (!leaf && !level)
                       || (leaf && level && |pte_q.ppn[VPN_LVL_W-1:0]);

    assign r_err    = (state == WALK_MREQ) && mem_r_valid && mem_r_err;
    assign walk_end = (state == WALK_PTE) && (leaf || struct_fault);

    assign walk.done      = walk_end || r_err;
    assign walk.fault     = (state == WALK_PTE) && struct_fault;
    assign walk.bus_err   = r_err;
    assign walk.pte       = pte_q;
    assign walk.superpage = level;

    assign fill.fill      = walk_end && !struct_fault;
    assign fill.vpn       = vpn_q;
    assign fill.superpage = level;
    assign fill.pte       = pte_q;

    always_comb begin
        state_nxt = state;
        case (state)
            WALK_IDLE: begin
                if (walk.start) begin
                    state_nxt = WALK_MREQ;
                end
            end
            WALK_MREQ: begin
                if (mem_r_valid) begin
                    state_nxt = mem_r_err ? WALK_IDLE : WALK_PTE;
                end
            end
            WALK_PTE: begin
                state_nxt = walk_end ? WALK_IDLE : WALK_MREQ;
            end
            default: begin
                state_nxt = WALK_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= WALK_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // address accepted, hold off until the data returns
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ar_done <= 1'b0;
        end else if (state != WALK_MREQ || mem_r_valid) begin
            ar_done <= 1'b0;
        end else if (mem_ar_valid && mem_ar_ready) begin
            ar_done <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            level <= 1'b1;
        end else if (state == WALK_IDLE && walk.start) begin
            level <= 1'b1;
        end else if (state == WALK_PTE && !walk_end) begin
            level <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (state == WALK_IDLE && walk.start) begin
            ppn_q <= satp_ppn;
            vpn_q <= walk.vpn;
        end else if (state == WALK_PTE && !walk_end) begin
            // descend through the pointer
            ppn_q <= pte_q.ppn;
        end
        if (state == WALK_MREQ && mem_r_valid) begin
            pte_q <= pte_t'(mem_r_data);
        end
    end

endmodule

//--- design/xlat_resolve.sv
`timescale 1ns/1ps

module xlat_resolve import mmu_pkg::*; (
    input  logic            clk,
    input  logic            rstn,
    input  logic            va_valid,
    input  logic [VA_W-1:0] va,
    input  access_e         access,
    input  prv_e            prv,
    input  logic            mprv,
    input  prv_e            mpp,
    input  logic            sum,
    input  logic            satp_mode,
    input  logic            pmp_v,
    input  logic            pmp_l,
    input  logic            pmp_r,
    input  logic            pmp_w,
    input  logic            pmp_x,
    walk_if.resolver        walk,
    lookup_if.resolver      lookup,
    output logic            pa_valid,
    output logic [PA_W-1:0] pa,
    output logic [1:0]      pa_bad
);

    // permission and privilege checks on a leaf
    function automatic logic leaf_fault(input pte_t p, input access_e acc,
                                        input prv_e pv, input logic s);
        logic perm;
        case (acc)
            ACC_WRITE: perm = p.w;
            ACC_EXEC:  perm = p.x;
            default:   perm = p.r;
        endcase
        return !perm
            || (pv == PRV_U && !p.u)
            || (pv == PRV_S && p.u && (!s || acc == ACC_EXEC))
            || (acc == ACC_WRITE && !p.d)
            || !p.a;
    endfunction

    function automatic logic [PA_W-1:0] leaf_pa(input pte_t p, input logic sp,
                                                input logic [VA_W-1:0] v);
        if (sp) begin
            return {p.ppn[PPN_W-1:VPN_LVL_W], v[PAGE_OFS_W+VPN_LVL_W-1:0]};
        end
        return {p.ppn, v[PAGE_OFS_W-1:0]};
    endfunction

    prv_e            prv_eff;
    logic            xlat_on;

    logic [VA_W-1:0] va_q;
    access_e         acc_q;
    prv_e            prv_q;
    logic            sum_q;

    // operands of whichever result is formed this cycle
    logic [VA_W-1:0] cur_va;
    access_e         cur_acc;
    prv_e            cur_prv;
    logic            cur_sum;
    pte_t            cur_pte;
    logic            cur_sp;
    logic            cur_bare;
    logic            cur_bus_err;
    logic            cur_walk_fault;

    logic            pmp_perm;
    logic            pmp_err;
    logic            pg_fault;
    logic            acc_fault;
    logic [PA_W-1:0] pa_d;
    logic            result_en;

    assign prv_eff = (mprv && access != ACC_EXEC) ? mpp : prv;
    assign xlat_on = (prv_eff != PRV_M) && satp_mode;

    assign lookup.vpn        = va[VA_W-1:PAGE_OFS_W];
    assign lookup.miss_clear = va_valid && xlat_on && !lookup.hit;
    assign walk.vpn          = va_q[VA_W-1:PAGE_OFS_W];

    // live request for bare or hit, latched request when the walk returns
    always_comb begin
        if (va_valid) begin
            cur_va         = va;
            cur_acc        = access;
            cur_prv        = prv_eff;
            cur_sum        = sum;
            cur_pte        = lookup.pte;
            cur_sp         = lookup.superpage;
            cur_bare       = !xlat_on;
            cur_bus_err    = 1'b0;
            cur_walk_fault = 1'b0;
        end else begin
            cur_va         = va_q;
            cur_acc        = acc_q;
            cur_prv        = prv_q;
            cur_sum        = sum_q;
            cur_pte        = walk.pte;
            cur_sp         = walk.superpage;
            cur_bare       = 1'b0;
            cur_bus_err    = walk.bus_err;
            cur_walk_fault = walk.fault;
        end
    end

    always_comb begin
        case (cur_acc)
            ACC_WRITE: pmp_perm = pmp_w;
            ACC_EXEC:  pmp_perm = pmp_x;
            default:   pmp_perm = pmp_r;
        endcase
    end

    assign pmp_err = (!pmp_v && cur_prv != PRV_M)
                  || ((pmp_l || cur_prv != PRV_M) && !pmp_perm);

    assign pa_d = cur_bare ? PA_W'(cur_va) : leaf_pa(cur_pte, cur_sp, cur_va);

    assign pg_fault = cur_walk_fault
                   || (!cur_bare && !cur_bus_err && !cur_walk_fault
                       && leaf_fault(cur_pte, cur_acc, cur_prv, cur_sum));

    assign acc_fault = (cur_bus_err || pmp_err || |pa_d[PA_W-1:BUS_W]) && !pg_fault;

    assign result_en = (va_valid && (!xlat_on || lookup.hit)) || walk.done;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pa_valid   <= 1'b0;
            walk.start <= 1'b0;
        end else begin
            pa_valid   <= result_en;
            walk.start <= va_valid && xlat_on && !lookup.hit;
        end
    end

    always_ff @(posedge clk) begin
        if (va_valid) begin
            va_q  <= va;
            acc_q <= access;
            prv_q <= prv_eff;
            sum_q <= sum;
        end
        if (result_en) begin
            pa     <= pa_d;
            pa_bad <= {acc_fault, pg_fault};
        end
    end

endmodule

//--- design/mmu_top.sv
`timescale 1ns/1ps

module mmu_top import mmu_pkg::*; (
    input  logic             clk,
    input  logic             rstn,

    // request
    input  logic             va_valid,
    input  logic [VA_W-1:0]  va,
    input  access_e          access,

    // privilege and satp
    input  prv_e             prv,
    input  logic             mprv,
    input  prv_e             mpp,
    input  logic             sum,
    input  logic             satp_mode,
    input  logic [PPN_W-1:0] satp_ppn,

    // single pmp region
    input  logic             pmp_v,
    input  logic             pmp_l,
    input  logic             pmp_r,
    input  logic             pmp_w,
    input  logic             pmp_x,

    input  logic             tlb_flush_req,

    // page table read port
    output logic             mem_ar_valid,
    output logic [BUS_W-1:0] mem_ar_addr,
    input  logic             mem_ar_ready,
    input  logic             mem_r_valid,
    input  logic [PTE_W-1:0] mem_r_data,
    input  logic             mem_r_err,

    // result
    output logic             pa_valid,
    output logic [PA_W-1:0]  pa,
    output logic [1:0]       pa_bad
);

    walk_if   walk ();
    fill_if   fill ();
    lookup_if lookup ();

    xlat_resolve u_resolve (
        .clk       (clk),
        .rstn      (rstn),
        .va_valid  (va_valid),
        .va        (va),
        .access    (access),
        .prv       (prv),
        .mprv      (mprv),
        .mpp       (mpp),
        .sum       (sum),
        .satp_mode (satp_mode),
        .pmp_v     (pmp_v),
        .pmp_l     (pmp_l),
        .pmp_r     (pmp_r),
        .pmp_w     (pmp_w),
        .pmp_x     (pmp_x),
        .walk      (walk.resolver),
        .lookup    (lookup.resolver),
        .pa_valid  (pa_valid),
        .pa        (pa),
        .pa_bad    (pa_bad)
    );

    page_walker u_walker (
        .clk          (clk),
        .rstn         (rstn),
        .satp_ppn     (satp_ppn),
        .walk         (walk.walker),
        .fill         (fill.walker),
        .mem_ar_valid (mem_ar_valid),
        .mem_ar_addr  (mem_ar_addr),
        .mem_ar_ready (mem_ar_ready),
        .mem_r_valid  (mem_r_valid),
        .mem_r_data   (mem_r_data),
        .mem_r_err    (mem_r_err)
    );

    last_xlat_cache u_cache (
        .clk           (clk),
        .rstn          (rstn),
        .tlb_flush_req (tlb_flush_req),
        .fill          (fill.cache),
        .lookup        (lookup.cache)
    );

endmodule

//--- tb/mmu_checker.sv
`timescale 1ns/1ps

module mmu_checker import mmu_pkg::*; (
    input  logic             clk,
    input  logic             rstn,
    input  logic             va_valid,
    input  logic [VA_W-1:0]  va,
    input  access_e          access,
    input  prv_e             prv,
    input  logic             mprv,
    input  prv_e             mpp,
    input  logic             sum,
    input  logic             satp_mode,
    input  logic [PPN_W-1:0] satp_ppn,
    // v, l, r, w, x
    input  logic [4:0]       pmp,
    input  logic             tlb_flush_req,
    input  logic             mem_ar_valid,
    input  logic [BUS_W-1:0] mem_ar_addr,
    input  logic             mem_ar_ready,
    input  logic             mem_r_valid,
    input  logic             mem_r_err,
    input  logic             pa_valid,
    input  logic [PA_W-1:0]  pa,
    input  logic [1:0]       pa_bad,
    input  int               cycle_limit,
    output logic             timed_out
);

    string            test_name = "none";
    int               checks    = 0;
    int               fails     = 0;
    int               t_checks  = 0;
    int               t_fails   = 0;
    int               cycles    = 0;

    // request in flight
    logic             busy      = 1'b0;
    int               lat;
    int               hs;
    logic             err_seen;

    logic [PA_W-1:0]  exp_pa;
    logic [1:0]       exp_bad;
    int               exp_reads;
    logic             exp_fast;
    logic             exp_fill;
    logic             exp_sp;
    logic [VPN_W-1:0] req_vpn;
    // pte read addresses, root level first
    logic [BUS_W-1:0] exp_addr [2];

    // shadow of the remembered translation
    logic             c_valid   = 1'b0;
    logic [VPN_W-1:0] c_vpn;
    logic             c_sp;

    assign timed_out = cycles > cycle_limit;

    task automatic start_test(input string name);
        test_name = name;
        t_checks  = 0;
        t_fails   = 0;
    endtask

    task automatic end_test();
        $display("test %s done: %0d checks, %0d mismatches", test_name, t_checks, t_fails);
    endtask

    task automatic check_val(input string what, input logic [PA_W-1:0] exp,
                             input logic [PA_W-1:0] act);
        checks++;
        t_checks++;
        if (exp !== act) begin
            fails++;
            t_fails++;
            $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    // walk the testbench tables, then leaf, pmp and range rules
    task automatic predict(input logic [VA_W-1:0] v, input prv_e pv, input logic xlat);
        pte_t p;
        logic pf;
        logic perm;
        logic deny;
        pf          = 1'b0;
        exp_sp      = 1'b1;
        exp_fill    = 1'b0;
        exp_reads   = 1;
        exp_pa      = {2'b00, v};
        exp_addr[0] = {satp_ppn[19:0], v[31:22], 2'b00};
        exp_addr[1] = '0;
        if (xlat) begin
            p = pte_t'(tb_mmu.pt_mem[{satp_ppn[1:0], v[31:22]}]);
            if (p.v && !p.r && !p.w && !p.x) begin
                exp_sp      = 1'b0;
                exp_reads   = 2;
                exp_addr[1] = {p.ppn[19:0], v[21:12], 2'b00};
                p  = pte_t'(tb_mmu.pt_mem[{p.ppn[1:0], v[21:12]}]);
                pf = !p.v || (p.w && !p.r) || (!p.r && !p.x);
            end else begin
                // level-1 leaf must sit on a 4 MiB boundary
                pf = !p.v || (p.w && !p.r) || (p.ppn[9:0] != 0);
            end
            exp_fill = !pf;
            exp_pa   = exp_sp ? {p.ppn[21:10], v[21:0]} : {p.ppn, v[11:0]};
            case (access)
                ACC_WRITE: perm = p.w;
                ACC_EXEC:  perm = p.x;
                default:   perm = p.r;
            endcase
            pf = pf || !perm || !p.a || (access == ACC_WRITE && !p.d)
              || (pv == PRV_U && !p.u)
              || (pv == PRV_S && p.u && (!sum || access == ACC_EXEC));
        end
        case (access)
            ACC_WRITE: perm = pmp[1];
            ACC_EXEC:  perm = pmp[0];
            default:   perm = pmp[2];
        endcase
        deny    = (!pmp[4] && pv != PRV_M) || ((pmp[3] || pv != PRV_M) && !perm);
        exp_bad = {(deny || exp_pa[PA_W-1:BUS_W] != 0) && !pf, pf};
    endtask

    task automatic start_req();
        prv_e pv;
        logic xlat;
        logic hit;
        pv   = (mprv && access != ACC_EXEC) ? mpp : prv;
        xlat = pv != PRV_M && satp_mode;
        predict(va, pv, xlat);
        req_vpn  = {va[31:22], exp_sp ? 10'd0 : va[21:12]};
        hit      = c_valid && c_vpn[19:10] == va[31:22] && (c_sp || c_vpn[9:0] == va[21:12]);
        exp_fast = !xlat || hit;
        if (xlat && !hit) begin
            c_valid = 1'b0;
        end
        busy     = 1'b1;
        lat      = 0;
        hs       = 0;
        err_seen = 1'b0;
    endtask

    task automatic finish_req();
        busy = 1'b0;
        if (exp_fast) begin
            check_val("latency", 1, lat);
            check_val("reads", 0, hs);
        end
        if (err_seen) begin
            check_val("pa_bad", 2'b10, pa_bad);
        end else begin
            check_val("pa_bad", exp_bad, pa_bad);
            if (!exp_bad[0]) begin
                check_val("pa", exp_pa, pa);
            end
            if (!exp_fast) begin
                check_val("reads", exp_reads, hs);
                if (exp_fill) begin
                    c_valid = 1'b1;
                    c_vpn   = req_vpn;
                    c_sp    = exp_sp;
                end
            end
        end
    endtask

    // sample mid-cycle, inputs and outputs are settled here
    always @(negedge clk) begin
        cycles++;
        if (!rstn) begin
            busy    = 1'b0;
            c_valid = 1'b0;
        end else begin
            if (tlb_flush_req) begin
                c_valid = 1'b0;
            end
            if (busy) begin
                lat++;
                if (mem_ar_valid && mem_ar_ready) begin
                    if (!exp_fast && hs < exp_reads) begin
                        check_val("ar_addr", exp_addr[hs], mem_ar_addr);
                    end
                    hs++;
                end
                if (mem_r_valid && mem_r_err) begin
                    err_seen = 1'b1;
                end
            end else if (mem_ar_valid) begin
                fails++;
                t_fails++;
                $display("%s: memory read issued with no request outstanding", test_name);
            end
            if (pa_valid && !busy) begin
                fails++;
                t_fails++;
                $display("%s: pa_valid arrived with no request outstanding", test_name);
            end else if (pa_valid) begin
                finish_req();
            end
            if (va_valid) begin
                start_req();
            end
        end
    end

endmodule

//--- tb/tb_mmu.sv
`timescale 1ns/1ps

module tb_mmu import mmu_pkg::*; ();

    localparam int MEM_WORDS   = 4096;
    localparam int RST_CYCLES  = 16;
    localparam int N_BARE      = 40;
    localparam int N_WALK      = 60;
    localparam int N_SUPER     = 40;
    // reuse runs in groups of four requests
    localparam int N_REUSE     = 10;
    localparam int N_ERR       = 40;
    localparam int N_REQ       = N_BARE + N_WALK + N_SUPER + 4 * N_REUSE + N_ERR;
    localparam int CYCLE_LIMIT = N_REQ * 60 + RST_CYCLES;

    logic             clk;
    logic             rstn;
    logic             va_valid;
    logic [VA_W-1:0]  va;
    access_e          access;
    prv_e             prv;
    logic             mprv;
    prv_e             mpp;
    logic             sum;
    logic             satp_mode;
    logic [PPN_W-1:0] satp_ppn;
    logic             pmp_v, pmp_l, pmp_r, pmp_w, pmp_x;
    logic             tlb_flush_req;
    logic             mem_ar_valid;
    logic [BUS_W-1:0] mem_ar_addr;
    logic             mem_ar_ready, mem_r_valid, mem_r_err;
    logic [PTE_W-1:0] mem_r_data;
    logic             pa_valid;
    logic [PA_W-1:0]  pa;
    logic [1:0]       pa_bad;
    logic             timed_out;

    // page tables, indexed by address bits 13:2
    logic [PTE_W-1:0] pt_mem [MEM_WORDS];
    int               seed;
    logic [VA_W-1:0]  page;

    mmu_top u_dut (.*);

    mmu_checker u_chk (
        .*,
        .pmp         ({pmp_v, pmp_l, pmp_r, pmp_w, pmp_x}),
        .cycle_limit (CYCLE_LIMIT)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic int rnd(input int n);
        return {$random(seed)} % n;
    endfunction

    function automatic prv_e pick_prv();
        case (rnd(3))
            0:       return PRV_U;
            1:       return PRV_S;
            default: return PRV_M;
        endcase
    endfunction

    // mostly valid, some misaligned superpages and ppns above 4 GiB
    function automatic logic [PTE_W-1:0] random_pte();
        pte_t p;
        p   = pte_t'($random(seed));
        p.v = rnd(8) != 0;
        p.a = rnd(8) != 0;
        p.d = rnd(4) != 0;
        if (rnd(4) == 0) begin
            {p.r, p.w, p.x} = 3'b000;
        end
        if (rnd(2) == 0) begin
            p.ppn[VPN_LVL_W-1:0] = '0;
        end
        if (rnd(4) != 0) begin
            p.ppn[PPN_W-1:PPN_W-2] = 2'b00;
        end
        return p;
    endfunction

    // va whose root entry is not a pointer
    function automatic logic [VA_W-1:0] super_va();
        logic [VA_W-1:0] v;
        pte_t            p;
        do begin
            v = $random(seed);
            p = pte_t'(pt_mem[{satp_ppn[1:0], v[31:22]}]);
        end while (!(p.r || p.w || p.x));
        return v;
    endfunction

    task automatic set_cfg(input logic machine_ok, input logic pmp_rand);
        prv       = machine_ok ? pick_prv() : prv_e'(rnd(2));
        mprv      = machine_ok && (rnd(2) != 0);
        mpp       = pick_prv();
        sum       = rnd(2) != 0;
        satp_mode = machine_ok ? (rnd(4) != 0) : 1'b1;
        access    = access_e'(rnd(3));
        {pmp_v, pmp_l, pmp_r, pmp_w, pmp_x} = pmp_rand ? 5'(rnd(32)) : 5'b10111;
    endtask

    task automatic send_req(input logic [VA_W-1:0] addr);
        va       = addr;
        va_valid = 1'b1;
        @(posedge clk);
        #1;
        va_valid = 1'b0;
        while (!pa_valid) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic pulse_flush();
        tlb_flush_req = 1'b1;
        @(posedge clk);
        #1;
        tlb_flush_req = 1'b0;
    endtask

    // one read outstanding, random ready and data delay
    initial begin : mem_model
        logic             pending;
        int               delay;
        logic [BUS_W-1:0] addr;
        logic             nxt_ready;
        logic             nxt_err;
        pending      = 1'b0;
        delay        = 0;
        addr         = '0;
        mem_ar_ready = 1'b0;
        mem_r_valid  = 1'b0;
        mem_r_data   = '0;
        mem_r_err    = 1'b0;
        forever begin
            @(negedge clk);
            if (mem_ar_valid && mem_ar_ready) begin
                pending = 1'b1;
                addr    = mem_ar_addr;
                delay   = rnd(6);
            end
            nxt_ready = rnd(4) != 0;
            nxt_err   = rnd(16) == 0;
            @(posedge clk);
            #1;
            mem_ar_ready = nxt_ready;
            mem_r_valid  = 1'b0;
            mem_r_err    = 1'b0;
            if (pending && delay == 0) begin
                pending     = 1'b0;
                mem_r_valid = 1'b1;
                mem_r_data  = pt_mem[addr[13:2]];
                mem_r_err   = nxt_err;
            end else if (pending) begin
                delay--;
            end
        end
    end

    always @(posedge timed_out) begin
        $display("timeout: no finish within %0d cycles", CYCLE_LIMIT);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        seed          = 32'h2309_cc20;
        rstn          = 1'b0;
        va_valid      = 1'b0;
        va            = '0;
        tlb_flush_req = 1'b0;
        set_cfg(1'b1, 1'b0);
        for (int i = 0; i < MEM_WORDS; i++) begin
            pt_mem[i] = random_pte();
        end
        satp_ppn = PPN_W'($random(seed));
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rstn = 1'b1;
        @(posedge clk);
        #1;

        u_chk.start_test("bare");
        repeat (N_BARE) begin
            set_cfg(1'b1, 1'b1);
            send_req($random(seed));
        end
        u_chk.end_test();

        u_chk.start_test("walk4k");
        repeat (N_WALK) begin
            set_cfg(1'b0, 1'b0);
            pulse_flush();
            send_req($random(seed));
        end
        u_chk.end_test();

        u_chk.start_test("superpage");
        repeat (N_SUPER) begin
            set_cfg(1'b0, 1'b0);
            send_req(super_va());
        end
        u_chk.end_test();

        // walk, hit, then flush or another page, then walk again
        u_chk.start_test("reuse");
        repeat (N_REUSE) begin
            set_cfg(1'b0, 1'b0);
            page = $random(seed);
            send_req(page);
            send_req({page[VA_W-1:PAGE_OFS_W], 12'(rnd(4096))});
            if (rnd(2) != 0) begin
                pulse_flush();
            end else begin
                send_req($random(seed));
            end
            send_req(page);
        end
        u_chk.end_test();

        u_chk.start_test("errors");
        repeat (N_ERR) begin
            set_cfg(1'b0, 1'b1);
            send_req($random(seed));
        end
        u_chk.end_test();

        $display("%0d checks, %0d failures", u_chk.checks, u_chk.fails);
        if (u_chk.fails == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
design/mmu_pkg.sv
design/mmu_ifs.sv
design/last_xlat_cache.sv
design/page_walker.sv
design/xlat_resolve.sv
design/mmu_top.sv
tb/mmu_checker.sv
tb/tb_mmu.sv
